// File: cam_bank.sv
`default_nettype none

module cam_bank import cam_mbist_pkg::*; #(
  parameter int NUM_ENTRIES = 32,
  parameter int DATA_WIDTH  = 16
) (
  input  logic       bist_clk,
  input  logic       reset,
  input  logic       wr_en,
  input  logic       rd_en,
  input  logic       srch_en,
  input  cam_addr_t  addr,
  input  cam_data_t  wdata,
  input  cam_data_t  srch_key,
  input  logic       fault_en,
  input  cam_addr_t  fault_entry,
  output cam_match_t match_lines,
  output cam_data_t  rdata
);

  // ==========================================================================
  // Entry storage
  // ==========================================================================

  logic [DATA_WIDTH-1:0]  mem [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] valid;

  // First pipeline stage
  logic                   srch_q;
  logic                   rd_q;
  cam_data_t              key_q;
  cam_addr_t              raddr_q;

  // Raw compare result before the output register
  logic [NUM_ENTRIES-1:0] hit;

  always_ff @(posedge bist_clk) begin
    if (wr_en) begin
      mem[addr] <= wdata;
    end
  end

  // Entries only take part in a search once written
  always_ff @(posedge bist_clk) begin
    if (reset) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[addr] <= 1'b1;
    end
  end

  // ==========================================================================
  // Stage 1 registers the key and the read address
  // ==========================================================================

  always_ff @(posedge bist_clk) begin
    if (reset) begin
      srch_q <= 1'b0;
      rd_q   <= 1'b0;
    end else begin
      srch_q <= srch_en;
      rd_q   <= rd_en;
    end
  end

  always_ff @(posedge bist_clk) begin
    key_q   <= srch_key;
    raddr_q <= addr;
  end

  // Parallel compare of the registered key against every entry
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      hit[i] = valid[i] && (mem[i] == key_q);
    end
    // Injected defect, match line stuck at zero
    if (fault_en) begin
      hit[fault_entry] = 1'b0;
    end
  end

  // ==========================================================================
  // Stage 2 registers the results
  // ==========================================================================

  // Lines hold the last search between operations
  always_ff @(posedge bist_clk) begin
    if (srch_q) begin
      match_lines <= hit;
    end
  end

  always_ff @(posedge bist_clk) begin
    if (rd_q) begin
      rdata <= mem[raddr_q];
    end
  end

endmodule

`default_nettype wire

// File: cam_fail_collector.sv
`default_nettype none

module cam_fail_collector import cam_mbist_pkg::*; #(
  parameter int NUM_BANKS = 4
) (
  input  logic                 bist_clk,
  input  logic                 reset,
  input  logic                 run_start,
  input  logic                 chk_en,
  input  logic                 chk_is_read,
  input  cam_data_t            exp_rdata,
  input  cam_data_t            rdata_out [NUM_BANKS],
  output logic [NUM_BANKS-1:0] fail_map
);

  // ==========================================================================
  // Strobe alignment with the bank pipeline
  // ==========================================================================

  logic                 chk_d1;
  logic                 chk_d2;
  logic                 read_d1;
  logic                 read_d2;
  cam_data_t            exp_d1;
  cam_data_t            exp_d2;
  logic [NUM_BANKS-1:0] bank_fail;

  always_ff @(posedge bist_clk) begin
    if (reset) begin
      chk_d1 <= 1'b0;
      chk_d2 <= 1'b0;
    end else begin
      chk_d1 <= chk_en;
      chk_d2 <= chk_d1;
    end
  end

  always_ff @(posedge bist_clk) begin
    read_d1 <= chk_is_read;
    read_d2 <= read_d1;
    exp_d1  <= exp_rdata;
    exp_d2  <= exp_d1;
  end

  // Search checks fail on any set bit, read checks on a data mismatch
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (read_d2) begin
        bank_fail[b] = chk_d2 && (rdata_out[b] != exp_d2);
      end else begin
        bank_fail[b] = chk_d2 && (|rdata_out[b]);
      end
    end
  end

  // Sticky per-bank fail bits, cleared as a new run starts
  always_ff @(posedge bist_clk) begin
    if (reset || run_start) begin
      fail_map <= '0;
    end else begin
      fail_map <= fail_map | bank_fail;
    end
  end

endmodule

`default_nettype wire

// File: cam_match_checker.sv
`default_nettype none

module cam_match_checker import cam_mbist_pkg::*; #(
  parameter int NUM_ENTRIES = 32,
  parameter int DATA_WIDTH  = 16
) (
  input  logic       bist_clk,
  input  logic       cm_mode,
  input  match_sel_t match_sel,
  input  cam_addr_t  bist_addr,
  input  cam_match_t match_lines,
  input  cam_data_t  rdata,
  output cam_data_t  rdata_out,
  output cam_match_t match_ref
);

  cam_addr_t              addr_d1;
  cam_addr_t              addr_d2;
  logic [NUM_ENTRIES-1:0] single_match;
  logic [NUM_ENTRIES-1:0] ref_lines;
  // One bit per entry that disagrees with the reference
  logic [NUM_ENTRIES-1:0] diff;
  logic [DATA_WIDTH-1:0]  cmp_word;

  // ==========================================================================
  // Expected match vector
  // ==========================================================================

  // Address follows the bank's two-stage search pipeline
  always_ff @(posedge bist_clk) begin
    addr_d1 <= bist_addr;
    addr_d2 <= addr_d1;
  end

  // One-hot decode of the aligned address
  always_comb begin
    single_match          = '0;
    single_match[addr_d2] = 1'b1;
  end

  always_comb begin
    case (match_sel)
      sel_all_match:       ref_lines = '1;
      sel_single_match:    ref_lines = single_match;
      sel_single_mismatch: ref_lines = ~single_match;
      sel_all_mismatch:    ref_lines = '0;
      default:             ref_lines = '0;
    endcase
  end

  assign match_ref = ref_lines;

  // ==========================================================================
  // Compare and compact
  // ==========================================================================

  assign diff = ref_lines ^ match_lines;

  generate
    if (DATA_WIDTH < NUM_ENTRIES) begin : g_compact
      // Entry i and i+DATA_WIDTH share one result bit
      always_comb begin
        cmp_word = '0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
          cmp_word[e % DATA_WIDTH] = cmp_word[e % DATA_WIDTH] | diff[e];
        end
      end
    end else if (DATA_WIDTH == NUM_ENTRIES) begin : g_equal
      assign cmp_word = diff;
    end else begin : g_expand
      // Narrow array, result packed into the upper bits
      assign cmp_word = {diff, {(DATA_WIDTH - NUM_ENTRIES){1'b0}}};
    end
  endgenerate

  // ==========================================================================
  // Read-data path
  // ==========================================================================

  // Miscompare word in CAM-check mode, normal data otherwise
  assign rdata_out = cm_mode ? cmp_word : rdata;

endmodule

`default_nettype wire

// File: cam_mbist_assertions.sv
`default_nettype none

module cam_mbist_assertions #(
  parameter int NUM_BANKS = 4
) (
  input logic                 bist_clk,
  input logic                 reset,
  input logic                 start_req,
  input logic                 start_ack,
  input logic [NUM_BANKS-1:0] fail_map
);

  // ==========================================================================
  // Start handshake
  // ==========================================================================

  // Ack only answers a live request
  ack_needs_req: assert property (@(posedge bist_clk) disable iff (reset)
    $rose(start_ack) |-> start_req)
    else $error("start_ack rose while start_req was low");

  // Ack holds as long as the request does
  ack_holds: assert property (@(posedge bist_clk) disable iff (reset)
    (start_ack && start_req) |=> start_ack)
    else $error("start_ack fell while start_req was high");

  // Ack drops one cycle after the request falls
  ack_drops: assert property (@(posedge bist_clk) disable iff (reset)
    (start_ack && $fell(start_req)) |=> !start_ack)
    else $error("start_ack still high one cycle after start_req fell");

  // Result stays put while it is being handed over
  map_stable: assert property (@(posedge bist_clk) disable iff (reset)
    (start_ack && $past(start_ack)) |-> $stable(fail_map))
    else $error("fail_map changed while start_ack was high");

endmodule

bind cam_mbist_top cam_mbist_assertions #(
  .NUM_BANKS (NUM_BANKS)
) u_assertions (
  .bist_clk  (bist_clk),
  .reset     (reset),
  .start_req (start_req),
  .start_ack (start_ack),
  .fail_map  (fail_map)
);

`default_nettype wire

// File: cam_mbist_ctrl.sv
`default_nettype none

module cam_mbist_ctrl import cam_mbist_pkg::*; (
  input  logic       bist_clk,
  input  logic       reset,
  input  logic       start_req,
  output logic       start_ack,
  output logic       wr_en,
  output logic       rd_en,
  output logic       srch_en,
  output logic       cm_mode,
  output logic       chk_en,
  output logic       chk_is_read,
  output match_sel_t match_sel,
  output cam_addr_t  addr,
  output cam_data_t  wdata,
  output cam_data_t  srch_key,
  output cam_data_t  exp_rdata,
  output logic       run_start
);

  ctrl_state_t state;
  // Where drain hands control back
  ctrl_state_t ret_state;
  // Check phase that drain is closing
  ctrl_state_t src_state;
  ctrl_state_t mode_state;
  cam_addr_t   addr_cnt;
  logic        last_addr;
  // Second phase A search uses the inverted key
  logic        second_key;
  // Phase A write pass reused to restore background before phase C
  logic        refill;
  logic        drain_cnt;

  assign last_addr = (addr_cnt == cam_addr_t'(cam_entries - 1));
  assign addr      = addr_cnt;
  assign start_ack = (state == done);
  assign run_start = (state == idle) && start_req;

  // ==========================================================================
  // Sequencer
  // ==========================================================================

  always_ff @(posedge bist_clk) begin
    if (reset) begin
      state      <= idle;
      ret_state  <= idle;
      src_state  <= idle;
      addr_cnt   <= '0;
      second_key <= 1'b0;
      refill     <= 1'b0;
      drain_cnt  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (start_req) begin
            state      <= a_write;
            addr_cnt   <= '0;
            second_key <= 1'b0;
            refill     <= 1'b0;
          end
        end
        a_write: begin
          addr_cnt <= addr_cnt + 1'b1;
          if (last_addr) begin
            state <= refill ? c_flip : a_search;
          end
        end
        a_search: begin
          // One search per key, each followed by a drain
          state     <= drain;
          src_state <= a_search;
          ret_state <= second_key ? b_write : a_search;
          drain_cnt <= 1'b0;
        end
        b_write: begin
          addr_cnt <= addr_cnt + 1'b1;
          if (last_addr) begin
            state <= b_read;
          end
        end
        b_read: begin
          addr_cnt <= addr_cnt + 1'b1;
          if (last_addr) begin
            state     <= drain;
            src_state <= b_read;
            ret_state <= b_search;
            drain_cnt <= 1'b0;
          end
        end
        b_search: begin
          addr_cnt <= addr_cnt + 1'b1;
          if (last_addr) begin
            state     <= drain;
            src_state <= b_search;
            ret_state <= a_write;
            refill    <= 1'b1;
            drain_cnt <= 1'b0;
          end
        end
        c_flip:   state <= c_search;
        c_search: state <= c_restore;
        c_restore: begin
          addr_cnt <= addr_cnt + 1'b1;
          if (last_addr) begin
            state     <= drain;
            src_state <= c_restore;
            ret_state <= done;
            drain_cnt <= 1'b0;
          end else begin
            state <= c_flip;
          end
        end
        drain: begin
          // Two idle cycles let the last check leave the bank pipeline
          drain_cnt <= 1'b1;
          if (drain_cnt) begin
            state      <= ret_state;
            second_key <= (ret_state == a_search);
          end
        end
        done: begin
          if (!start_req) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // ==========================================================================
  // Operation decode
  // ==========================================================================

  always_comb begin
    wr_en       = 1'b0;
    rd_en       = 1'b0;
    srch_en     = 1'b0;
    chk_is_read = 1'b0;
    wdata       = common_word;
    srch_key    = common_word;
    exp_rdata   = unique_word_of(addr_cnt);
    case (state)
      a_write:   wr_en = 1'b1;
      a_search: begin
        srch_en  = 1'b1;
        srch_key = second_key ? ~common_word : common_word;
      end
      b_write: begin
        wr_en = 1'b1;
        wdata = unique_word_of(addr_cnt);
      end
      b_read: begin
        rd_en       = 1'b1;
        chk_is_read = 1'b1;
      end
      b_search: begin
        srch_en  = 1'b1;
        srch_key = unique_word_of(addr_cnt);
      end
      c_flip: begin
        wr_en = 1'b1;
        wdata = ~common_word;
      end
      // Only the flipped entry should miss the background key
      c_search:  srch_en = 1'b1;
      c_restore: wr_en = 1'b1;
      default: ;
    endcase
  end

  assign chk_en = srch_en | rd_en;

  // Drain keeps the mode of the phase it closes
  assign mode_state = (state == drain) ? src_state : state;

  always_comb begin
    cm_mode   = 1'b0;
    match_sel = sel_all_match;
    case (mode_state)
      a_search: begin
        cm_mode   = 1'b1;
        match_sel = second_key ? sel_all_mismatch : sel_all_match;
      end
      b_search: begin
        cm_mode   = 1'b1;
        match_sel = sel_single_match;
      end
      c_flip, c_search, c_restore: begin
        cm_mode   = 1'b1;
        match_sel = sel_single_mismatch;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: cam_mbist_pkg.sv
`default_nettype none

package cam_mbist_pkg;

  // ==========================================================================
  // Array geometry shared by the whole MBIST subsystem
  // ==========================================================================

  localparam int cam_data_w  = 16;
  localparam int cam_entries = 32;
  localparam int cam_addr_w  = 5;

  typedef logic [cam_data_w-1:0]  cam_data_t;
  typedef logic [cam_addr_w-1:0]  cam_addr_t;
  typedef logic [cam_entries-1:0] cam_match_t;

  // Expected match pattern selector, same coding as the CAM test hook
  typedef enum logic [1:0] {
    sel_all_match       = 2'b00,
    sel_single_match    = 2'b01,
    sel_single_mismatch = 2'b10,
    sel_all_mismatch    = 2'b11
  } match_sel_t;

  // Sequencer states, one group per algorithm phase
  typedef enum logic [3:0] {
    idle,
    a_write, a_search,
    b_write, b_read, b_search,
    c_flip, c_search, c_restore,
    drain,
    done
  } ctrl_state_t;

  // Background word for phases A and C
  localparam cam_data_t common_word = 16'hA5C3;

  // Phase B word, address replicated across the word then scrambled
  function automatic cam_data_t unique_word_of(input cam_addr_t a);
    unique_word_of = {a, a, a, a[0]} ^ common_word;
  endfunction

endpackage

`default_nettype wire

// File: cam_mbist_top.f
cam_mbist_pkg.sv
cam_mbist_ctrl.sv
cam_bank.sv
cam_match_checker.sv
cam_fail_collector.sv
cam_mbist_top.sv
cam_mbist_assertions.sv
tb_cam_mbist.sv

// File: cam_mbist_top.sv
`default_nettype none

module cam_mbist_top import cam_mbist_pkg::*; #(
  parameter int NUM_BANKS   = 4,
  parameter int NUM_ENTRIES = 32,
  parameter int DATA_WIDTH  = 16
) (
  input  logic                 bist_clk,
  input  logic                 reset,
  input  logic                 start_req,
  input  logic                 fault_en,
  input  logic [1:0]           fault_bank,
  input  cam_addr_t            fault_entry,
  output logic                 start_ack,
  output logic [NUM_BANKS-1:0] fail_map
);

  // ==========================================================================
  // Broadcast control from the sequencer
  // ==========================================================================

  logic       wr_en;
  logic       rd_en;
  logic       srch_en;
  logic       cm_mode;
  logic       chk_en;
  logic       chk_is_read;
  logic       run_start;
  match_sel_t match_sel;
  cam_addr_t  addr;
  cam_data_t  wdata;
  cam_data_t  srch_key;
  cam_data_t  exp_rdata;
  // Checker output of every bank
  cam_data_t  bank_rdata_out [NUM_BANKS];

  cam_mbist_ctrl u_ctrl (
    .bist_clk    (bist_clk),
    .reset       (reset),
    .start_req   (start_req),
    .start_ack   (start_ack),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .srch_en     (srch_en),
    .cm_mode     (cm_mode),
    .chk_en      (chk_en),
    .chk_is_read (chk_is_read),
    .match_sel   (match_sel),
    .addr        (addr),
    .wdata       (wdata),
    .srch_key    (srch_key),
    .exp_rdata   (exp_rdata),
    .run_start   (run_start)
  );

  // ==========================================================================
  // Banks in lockstep, each with its own checker
  // ==========================================================================

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    cam_match_t match_lines;
    cam_data_t  rdata;
    logic       bank_fault_en;

    // Fault reaches the selected bank only
    assign bank_fault_en = fault_en && (fault_bank == 2'(b));

    cam_bank #(
      .NUM_ENTRIES (NUM_ENTRIES),
      .DATA_WIDTH  (DATA_WIDTH)
    ) u_bank (
      .bist_clk    (bist_clk),
      .reset       (reset),
      .wr_en       (wr_en),
      .rd_en       (rd_en),
      .srch_en     (srch_en),
      .addr        (addr),
      .wdata       (wdata),
      .srch_key    (srch_key),
      .fault_en    (bank_fault_en),
      .fault_entry (fault_entry),
      .match_lines (match_lines),
      .rdata       (rdata)
    );

    cam_match_checker #(
      .NUM_ENTRIES (NUM_ENTRIES),
      .DATA_WIDTH  (DATA_WIDTH)
    ) u_checker (
      .bist_clk    (bist_clk),
      .cm_mode     (cm_mode),
      .match_sel   (match_sel),
      .bist_addr   (addr),
      .match_lines (match_lines),
      .rdata       (rdata),
      .rdata_out   (bank_rdata_out[b]),
      .match_ref   ()
    );
  end

  cam_fail_collector #(
    .NUM_BANKS (NUM_BANKS)
  ) u_collector (
    .bist_clk    (bist_clk),
    .reset       (reset),
    .run_start   (run_start),
    .chk_en      (chk_en),
    .chk_is_read (chk_is_read),
    .exp_rdata   (exp_rdata),
    .rdata_out   (bank_rdata_out),
    .fail_map    (fail_map)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the CAM MBIST testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cam_mbist \
  -f cam_mbist_top.f \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

grep -q "TB PASSED" sim.log

// File: tb_cam_mbist.sv
`default_nettype none

module tb_cam_mbist;

  // ==========================================================================
  // Bench constants
  // ==========================================================================

  localparam int NUM_BANKS   = 4;
  localparam int NUM_ENTRIES = 32;
  localparam int DATA_WIDTH  = 16;
  localparam int CLK_PERIOD  = 20;
  // Budget per run, well above the algorithm length
  localparam int RUN_CYCLES  = 500;
  localparam int MAX_RUNS    = 8;
  localparam int NUM_FAULTS  = 5;

  logic                 bist_clk;
  logic                 reset;
  logic                 start_req;
  logic                 fault_en;
  logic [1:0]           fault_bank;
  logic [4:0]           fault_entry;
  logic                 start_ack;
  logic [NUM_BANKS-1:0] fail_map;

  logic [15:0]          lfsr_state;
  int                   error_count;
  int                   runs_started;
  int                   runs_checked;
  // Run in flight and its expected map, shared with the compare process
  string                cur_name;
  logic [NUM_BANKS-1:0] cur_expected;

  cam_mbist_top #(
    .NUM_BANKS   (NUM_BANKS),
    .NUM_ENTRIES (NUM_ENTRIES),
    .DATA_WIDTH  (DATA_WIDTH)
  ) u_dut (
    .bist_clk    (bist_clk),
    .reset       (reset),
    .start_req   (start_req),
    .fault_en    (fault_en),
    .fault_bank  (fault_bank),
    .fault_entry (fault_entry),
    .start_ack   (start_ack),
    .fail_map    (fail_map)
  );

  initial begin
    bist_clk = 1'b0;
    forever #(CLK_PERIOD / 2) bist_clk = ~bist_clk;
  end

  // ==========================================================================
  // Stimulus helpers and reference model
  // ==========================================================================

  // x^16 + x^14 + x^13 + x^11 + 1, shifting toward the MSB
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    lfsr_next = {s[14:0], fb};
  endfunction

  // One LFSR step per bit, newest bit lands in the LSB
  task automatic draw_bits(input int n, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[6:0], lfsr_state[0]};
    end
  endtask

  // Stuck-zero line misses the all-match search, so only its own bank fails
  function automatic logic [NUM_BANKS-1:0] expected_fail_map(input logic       f_en,
                                                             input logic [1:0] f_bank);
    expected_fail_map = '0;
    if (f_en) begin
      expected_fail_map[f_bank] = 1'b1;
    end
  endfunction

  // Full four-phase handshake for one MBIST run
  task automatic run_test(input string name, input logic f_en, input logic [1:0] f_bank,
                          input logic [4:0] f_entry);
    @(negedge bist_clk);
    if (start_ack) begin
      $display("%s: start_ack still high before the request", name);
      error_count++;
    end
    cur_name     = name;
    cur_expected = expected_fail_map(f_en, f_bank);
    fault_en     = f_en;
    fault_bank   = f_bank;
    fault_entry  = f_entry;
    start_req    = 1'b1;
    runs_started++;
    // Sticky map clears as the controller leaves idle
    @(negedge bist_clk);
    if (fail_map !== '0) begin
      $display("Error %s_clear: expected %b, actual %b", name, {NUM_BANKS{1'b0}}, fail_map);
      error_count++;
    end
    while (!start_ack) begin
      @(negedge bist_clk);
    end
    // Ack must hold while the request is held
    repeat (3) begin
      @(negedge bist_clk);
      if (!start_ack) begin
        $display("%s: start_ack dropped while start_req was still high", name);
        error_count++;
      end
    end
    start_req = 1'b0;
    @(negedge bist_clk);
    if (start_ack) begin
      $display("%s: start_ack did not drop one cycle after start_req fell", name);
      error_count++;
    end
  endtask

  // ==========================================================================
  // Compare process and watchdog
  // ==========================================================================

  initial begin : compare_proc
    forever begin
      @(posedge start_ack);
      @(negedge bist_clk);
      if (fail_map !== cur_expected) begin
        $display("Error %s: expected %b, actual %b", cur_name, cur_expected, fail_map);
        error_count++;
      end
      runs_checked++;
    end
  end

  initial begin : watchdog
    #(MAX_RUNS * RUN_CYCLES * CLK_PERIOD);
    $display("Timeout in %s: start_ack never arrived", cur_name);
    $display("Errors: %0d, runs checked: %0d of %0d", error_count, runs_checked, runs_started);
    $display("TB FAILED");
    $finish;
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================

  initial begin : stimulus
    logic [7:0] pick_bank;
    logic [7:0] pick_entry;
    reset        = 1'b1;
    start_req    = 1'b0;
    fault_en     = 1'b0;
    fault_bank   = 2'd0;
    fault_entry  = 5'd0;
    lfsr_state   = 16'd22213;
    error_count  = 0;
    runs_started = 0;
    runs_checked = 0;
    cur_name     = "after_reset";
    cur_expected = '0;
    repeat (4) @(negedge bist_clk);
    reset = 1'b0;
    @(negedge bist_clk);
    // Quiet outputs before any request
    if (start_ack !== 1'b0) begin
      $display("Error after_reset_ack: expected 0, actual %b", start_ack);
      error_count++;
    end
    if (fail_map !== '0) begin
      $display("Error after_reset_map: expected %b, actual %b", {NUM_BANKS{1'b0}}, fail_map);
      error_count++;
    end
    run_test("no_fault", 1'b0, 2'd0, 5'd0);
    for (int k = 0; k < NUM_FAULTS; k++) begin
      draw_bits(2, pick_bank);
      draw_bits(5, pick_entry);
      run_test($sformatf("fault_%0d_bank%0d_entry%0d", k, pick_bank[1:0], pick_entry[4:0]),
               1'b1, pick_bank[1:0], pick_entry[4:0]);
    end
    // Map from the last faulted run must not survive
    run_test("clear_after_fault", 1'b0, 2'd0, 5'd0);
    repeat (3) @(negedge bist_clk);
    if (runs_checked != runs_started) begin
      $display("Compare process saw %0d completed runs, expected %0d", runs_checked,
               runs_started);
      error_count++;
    end
    $display("Errors: %0d, runs checked: %0d of %0d", error_count, runs_checked, runs_started);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
